// ==== filelist.f ====
+incdir+dv
hdl/ExecTypes.sv
hdl/IntAlu.sv
hdl/BranchUnit.sv
hdl/MulDivUnit.sv
hdl/TrapDetect.sv
hdl/ExecuteStage.sv
dv/ExecuteStageTb.sv

// ==== dv/ExecRefModel.svh ====
// ========================================
// Reference rules of the execute stage
// ALU commands, branch condition and target,
// mul/div results and trap causes
// ========================================
`ifndef ExecRefModelSvh
`define ExecRefModelSvh

function automatic ExecTypes::word_t refAlu(input ExecTypes::aluCmd_t cmd,
                                            input ExecTypes::word_t a,
                                            input ExecTypes::word_t b);
    int unsigned sh;
    sh = b[4:0];
    case (cmd)
        ExecTypes::AluCmdAdd:    return a + b;
        ExecTypes::AluCmdSub:    return a - b;
        ExecTypes::AluCmdSll:    return a << sh;
        ExecTypes::AluCmdSlt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        ExecTypes::AluCmdSltu:   return (a < b) ? 32'd1 : 32'd0;
        ExecTypes::AluCmdXor:    return a ^ b;
        ExecTypes::AluCmdSrl:    return a >> sh;
        ExecTypes::AluCmdSra:    return $signed(a) >>> sh;
        ExecTypes::AluCmdOr:     return a | b;
        ExecTypes::AluCmdAnd:    return a & b;
        ExecTypes::AluCmdClear1: return a & ~b;
        ExecTypes::AluCmdClear2: return b & ~a;
        default:                 return '0;
    endcase
endfunction

function automatic logic refTaken(input ExecTypes::branchCond_t cond,
                                  input ExecTypes::word_t a,
                                  input ExecTypes::word_t b);
    case (cond)
        ExecTypes::BranchCondEq:     return a == b;
        ExecTypes::BranchCondNe:     return a != b;
        ExecTypes::BranchCondLt:     return $signed(a) < $signed(b);
        ExecTypes::BranchCondGe:     return $signed(a) >= $signed(b);
        ExecTypes::BranchCondLtu:    return a < b;
        ExecTypes::BranchCondGeu:    return a >= b;
        ExecTypes::BranchCondAlways: return 1'b1;
        default:                     return 1'b0;
    endcase
endfunction

function automatic ExecTypes::word_t refTarget(input logic indirect,
                                               input ExecTypes::word_t pc,
                                               input ExecTypes::word_t rs1,
                                               input ExecTypes::word_t imm);
    if (indirect) begin
        return (rs1 + imm) & ~32'd1;
    end
    return pc + imm;
endfunction

function automatic ExecTypes::word_t refNextPc(input ExecTypes::word_t pc,
                                               input logic isCompressed);
    return isCompressed ? pc + 32'd2 : pc + 32'd4;
endfunction

function automatic ExecTypes::word_t refMulDiv(input ExecTypes::mulDivCmd_t cmd,
                                               input ExecTypes::word_t a,
                                               input ExecTypes::word_t b);
    logic [63:0] p;
    logic ovf;
    int sa;
    int sb;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    sa = a;
    sb = b;
    case (cmd)
        ExecTypes::MulDivCmdMul:    return a * b;
        ExecTypes::MulDivCmdMulh: begin
            p = longint'($signed(a)) * longint'($signed(b));
            return p[63:32];
        end
        ExecTypes::MulDivCmdMulhsu: begin
            p = longint'($signed(a)) * longint'({32'd0, b});
            return p[63:32];
        end
        ExecTypes::MulDivCmdMulhu: begin
            p = {32'd0, a} * {32'd0, b};
            return p[63:32];
        end
        ExecTypes::MulDivCmdDiv: begin
            if (b == 0) return '1;
            if (ovf) return a;
            return sa / sb;
        end
        ExecTypes::MulDivCmdDivu: return (b == 0) ? '1 : a / b;
        ExecTypes::MulDivCmdRem: begin
            if (b == 0) return a;
            if (ovf) return '0;
            return sa % sb;
        end
        default:                  return (b == 0) ? a : a % b;
    endcase
endfunction

function automatic logic [ExecTypes::CauseWidth-1:0] refCause(
        input ExecTypes::trapOp_t trapOp, input ExecTypes::privilege_t priv);
    if (trapOp == ExecTypes::TrapOpEbreak) return 5'd3;
    case (priv)
        ExecTypes::PrivilegeUser:       return 5'd8;
        ExecTypes::PrivilegeSupervisor: return 5'd9;
        default:                        return 5'd11;
    endcase
endfunction

`endif

// ==== dv/ExecuteStageTb.sv ====
// ========================================
// Testbench for the integer execute stage
// ALU, branch, mul/div and trap operations,
// checked by concurrent assertions
// ========================================
`timescale 1ns/1ps

module ExecuteStageTb;

    // about 300 operations at up to 36 cycles, plus margin
    localparam int MaxCycles = 20000;

    logic clk;
    logic rstN;
    ExecTypes::stageIn_t stim;
    ExecTypes::privilege_t privilege;
    ExecTypes::stageOut_t out;
    logic stallReq;
    logic flushReq;
    ExecTypes::word_t flushTarget;

    int seed;
    int cycleCount;
    logic accepted;
    logic isMdOp;
    logic expValid;
    ExecTypes::stageOut_t expOut;

    `include "ExecRefModel.svh"

    ExecuteStage UUT (
        .clk(clk),
        .rstN(rstN),
        .in(stim),
        .privilege(privilege),
        .out(out),
        .stallReq(stallReq),
        .flushReq(flushReq),
        .flushTarget(flushTarget)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        failRun($sformatf("ERR at %0t: %s expected %h, got %h", $time, name, expected, actual));
    endtask

    function automatic ExecTypes::stageOut_t expectedOut(input ExecTypes::stageIn_t s,
                                                         input ExecTypes::privilege_t priv);
        ExecTypes::stageOut_t e;
        ExecTypes::word_t a;
        ExecTypes::word_t b;
        e = '0;
        a = (s.op.aluSrc1 == ExecTypes::AluSrc1Pc) ? s.pc :
            (s.op.aluSrc1 == ExecTypes::AluSrc1Reg) ? s.rs1Value : '0;
        b = (s.op.aluSrc2 == ExecTypes::AluSrc2Imm) ? s.op.imm :
            (s.op.aluSrc2 == ExecTypes::AluSrc2Reg) ? s.rs2Value : '0;
        e.valid = 1'b1;
        e.pc = s.pc;
        e.rd = s.op.rd;
        e.regWrite = s.op.regWrite;
        if (s.op.writeSrc == ExecTypes::WriteSrcNextPc) begin
            e.dstValue = refNextPc(s.pc, s.isCompressed);
        end else if (s.op.unit == ExecTypes::ExecUnitMulDiv) begin
            e.dstValue = refMulDiv(s.op.mulDivCmd, s.rs1Value, s.rs2Value);
        end else begin
            e.dstValue = refAlu(s.op.aluCmd, a, b);
        end
        e.branchTaken = s.op.unit == ExecTypes::ExecUnitBranch &&
                        refTaken(s.op.branchCond, s.rs1Value, s.rs2Value);
        e.branchTarget = refTarget(s.op.indirect, s.pc, s.rs1Value, s.op.imm);
        if (s.op.unit == ExecTypes::ExecUnitTrap) begin
            e.trap.valid = 1'b1;
            e.trap.cause = refCause(s.op.trapOp, priv);
        end
        return e;
    endfunction

    function automatic logic refFlush(input ExecTypes::stageIn_t s);
        return s.op.unit == ExecTypes::ExecUnitTrap || (s.op.unit == ExecTypes::ExecUnitBranch
               && refTaken(s.op.branchCond, s.rs1Value, s.rs2Value));
    endfunction

    function automatic ExecTypes::word_t refFlushTarget(input ExecTypes::stageIn_t s);
        if (s.op.unit == ExecTypes::ExecUnitTrap) return refNextPc(s.pc, s.isCompressed);
        return refTarget(s.op.indirect, s.pc, s.rs1Value, s.op.imm);
    endfunction

    always_comb begin
        isMdOp = stim.valid && stim.op.unit == ExecTypes::ExecUnitMulDiv;
        accepted = stim.valid && !stallReq;
    end

    // one-entry expected register, loads with the accepted op
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            expValid <= 1'b0;
            expOut <= '0;
        end else begin
            expValid <= accepted;
            if (accepted) expOut <= expectedOut(stim, privilege);
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) failRun("run hung: cycle limit reached");
    end

    validCheck: assert property (@(posedge clk) disable iff (!rstN) out.valid == expValid)
        else reportMismatch("out.valid", $sampled(expValid), $sampled(out.valid));
    dstCheck: assert property (@(posedge clk) disable iff (!rstN)
        out.valid |-> out.dstValue == expOut.dstValue)
        else reportMismatch("out.dstValue", $sampled(expOut.dstValue), $sampled(out.dstValue));
    pcCheck: assert property (@(posedge clk) disable iff (!rstN)
        out.valid |-> out.pc == expOut.pc)
        else reportMismatch("out.pc", $sampled(expOut.pc), $sampled(out.pc));
    rdCheck: assert property (@(posedge clk) disable iff (!rstN)
        out.valid |-> out.rd == expOut.rd)
        else reportMismatch("out.rd", $sampled(expOut.rd), $sampled(out.rd));
    regWriteCheck: assert property (@(posedge clk) disable iff (!rstN)
        out.valid |-> out.regWrite == expOut.regWrite)
        else reportMismatch("out.regWrite", $sampled(expOut.regWrite),
                            $sampled(out.regWrite));
    takenCheck: assert property (@(posedge clk) disable iff (!rstN)
        out.valid |-> out.branchTaken == expOut.branchTaken)
        else reportMismatch("out.branchTaken", $sampled(expOut.branchTaken),
                            $sampled(out.branchTaken));
    branchTargetCheck: assert property (@(posedge clk) disable iff (!rstN)
        out.valid |-> out.branchTarget == expOut.branchTarget)
        else reportMismatch("out.branchTarget", $sampled(expOut.branchTarget),
                            $sampled(out.branchTarget));
    trapCheck: assert property (@(posedge clk) disable iff (!rstN)
        out.valid |-> out.trap == expOut.trap)
        else reportMismatch("out.trap", $sampled(expOut.trap), $sampled(out.trap));
    flushCheck: assert property (@(posedge clk) disable iff (!rstN)
        flushReq == (accepted && refFlush(stim)))
        else reportMismatch("flushReq", $sampled(accepted && refFlush(stim)), $sampled(flushReq));
    targetCheck: assert property (@(posedge clk) disable iff (!rstN)
        flushReq |-> flushTarget == refFlushTarget(stim))
        else reportMismatch("flushTarget", $sampled(refFlushTarget(stim)), $sampled(flushTarget));
    stallCheck: assert property (@(posedge clk) disable iff (!rstN) !isMdOp |-> !stallReq)
        else reportMismatch("stallReq", 64'd0, $sampled(stallReq));
    mdStallCheck: assert property (@(posedge clk) disable iff (!rstN)
        accepted && isMdOp |-> $past(stallReq))
        else failRun("mul/div operation was accepted without a stall cycle");

    task automatic buildOp(input ExecTypes::execUnit_t unit, output ExecTypes::stageIn_t s);
        s = '0;
        s.valid = 1'b1;
        s.pc = $random(seed);
        s.pc[0] = 1'b0;
        s.insn = $random(seed);
        s.isCompressed = 1'($random(seed));
        s.rs1Value = $random(seed);
        // equal operands now and then, so Eq/Ne/Ge both ways
        s.rs2Value = (($random(seed) & 3) == 0) ? s.rs1Value : $random(seed);
        s.op.unit = unit;
        s.op.aluCmd = ExecTypes::aluCmd_t'($unsigned($random(seed)) % 12);
        s.op.aluSrc1 = ExecTypes::aluSrc1_t'($unsigned($random(seed)) % 3);
        s.op.aluSrc2 = ExecTypes::aluSrc2_t'($unsigned($random(seed)) % 3);
        s.op.writeSrc = ExecTypes::WriteSrcResult;
        s.op.branchCond = ExecTypes::branchCond_t'($unsigned($random(seed)) % 7);
        s.op.indirect = 1'($random(seed));
        s.op.mulDivCmd = ExecTypes::mulDivCmd_t'($random(seed) & 7);
        s.op.trapOp = ExecTypes::TrapOpEcall;
        s.op.imm = $random(seed);
        s.op.rd = 5'($random(seed));
        s.op.regWrite = 1'($random(seed));
    endtask

    // present one op on the falling edge, hold it while stalled
    task automatic runOp(input ExecTypes::stageIn_t s);
        stim = s;
        #1;
        while (stallReq) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
    endtask

    task automatic runMulDiv(input ExecTypes::mulDivCmd_t cmd, input ExecTypes::word_t a,
                             input ExecTypes::word_t b);
        ExecTypes::stageIn_t s;
        buildOp(ExecTypes::ExecUnitMulDiv, s);
        s.op.mulDivCmd = cmd;
        s.rs1Value = a;
        s.rs2Value = b;
        runOp(s);
    endtask

    initial begin
        ExecTypes::stageIn_t s;
        seed = 32'ha3e07bb8;
        cycleCount = 0;
        rstN = 1'b0;
        stim = '0;
        privilege = ExecTypes::PrivilegeMachine;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        repeat (3) @(negedge clk);

        // every ALU command with every operand source pair
        for (int i = 0; i < 108; i++) begin
            buildOp(ExecTypes::ExecUnitAlu, s);
            s.op.aluCmd = ExecTypes::aluCmd_t'(i % 12);
            s.op.aluSrc1 = ExecTypes::aluSrc1_t'((i / 12) % 3);
            s.op.aluSrc2 = ExecTypes::aluSrc2_t'((i / 36) % 3);
            runOp(s);
        end

        for (int i = 0; i < 56; i++) begin
            buildOp(ExecTypes::ExecUnitBranch, s);
            s.op.branchCond = ExecTypes::branchCond_t'(i % 7);
            s.op.indirect = 1'((i / 7) % 2);
            if (s.op.branchCond == ExecTypes::BranchCondAlways) begin
                s.op.writeSrc = ExecTypes::WriteSrcNextPc;
                s.isCompressed = 1'((i / 14) % 2);
            end
            runOp(s);
        end

        for (int i = 0; i < 48; i++) begin
            runMulDiv(ExecTypes::mulDivCmd_t'(i % 8), $random(seed), $random(seed));
        end

        // division by zero and signed overflow
        for (int i = 4; i < 8; i++) begin
            runMulDiv(ExecTypes::mulDivCmd_t'(i), $random(seed), '0);
            runMulDiv(ExecTypes::mulDivCmd_t'(i), 32'h8000_0000, 32'hffff_ffff);
        end

        // mul/div mixed with ALU ops, no gaps
        for (int i = 0; i < 40; i++) begin
            buildOp(($random(seed) & 1) ? ExecTypes::ExecUnitMulDiv : ExecTypes::ExecUnitAlu, s);
            runOp(s);
        end

        for (int i = 0; i < 4; i++) begin
            buildOp(ExecTypes::ExecUnitTrap, s);
            s.op.trapOp = (i == 3) ? ExecTypes::TrapOpEbreak : ExecTypes::TrapOpEcall;
            privilege = (i == 0) ? ExecTypes::PrivilegeUser :
                        (i == 1) ? ExecTypes::PrivilegeSupervisor : ExecTypes::PrivilegeMachine;
            runOp(s);
        end

        stim = '0;
        repeat (4) @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== hdl/ExecuteStage.sv ====
// ======================================
// Integer execute stage, top level
// operand select, result select,
// stall and flush control, output register
// ======================================
`timescale 1ns/1ps

module ExecuteStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  ExecTypes::stageIn_t   in,
    input  ExecTypes::privilege_t privilege,
    output ExecTypes::stageOut_t  out,
    output logic                  stallReq,
    output logic                  flushReq,
    output ExecTypes::word_t      flushTarget
);

    ExecTypes::execOp_t op;
    ExecTypes::word_t aluSrc1;
    ExecTypes::word_t aluSrc2;
    ExecTypes::word_t aluResult;
    logic condTaken;
    ExecTypes::word_t branchTarget;
    logic branchTaken;
    ExecTypes::trapInfo_t trap;
    logic mdReq;
    logic mdAck;
    ExecTypes::mulDivReq_t mdArgs;
    ExecTypes::word_t mdResult;
    logic isMulDiv;
    logic accept;
    ExecTypes::word_t nextPc;
    ExecTypes::word_t dstValue;

    always_comb begin
        op = in.op;

        case (op.aluSrc1)
            ExecTypes::AluSrc1Pc:  aluSrc1 = in.pc;
            ExecTypes::AluSrc1Reg: aluSrc1 = in.rs1Value;
            default:               aluSrc1 = '0;
        endcase

        case (op.aluSrc2)
            ExecTypes::AluSrc2Imm: aluSrc2 = op.imm;
            ExecTypes::AluSrc2Reg: aluSrc2 = in.rs2Value;
            default:               aluSrc2 = '0;
        endcase

        mdArgs.cmd = op.mulDivCmd;
        mdArgs.src1 = in.rs1Value;
        mdArgs.src2 = in.rs2Value;
    end

    IntAlu alu (
        .cmd(op.aluCmd),
        .src1(aluSrc1),
        .src2(aluSrc2),
        .result(aluResult)
    );

    BranchUnit branchUnit (
        .cond(op.branchCond),
        .indirect(op.indirect),
        .pc(in.pc),
        .rs1Value(in.rs1Value),
        .rs2Value(in.rs2Value),
        .imm(op.imm),
        .taken(condTaken),
        .target(branchTarget)
    );

    MulDivUnit mulDiv (
        .clk(clk),
        .rstN(rstN),
        .mdReq(mdReq),
        .mdArgs(mdArgs),
        .mdAck(mdAck),
        .mdResult(mdResult)
    );

    TrapDetect trapDetect (
        .valid(in.valid),
        .op(op),
        .privilege(privilege),
        .trap(trap)
    );

    always_comb begin
        isMulDiv = in.valid && op.unit == ExecTypes::ExecUnitMulDiv;
        // mul/div retires in the cycle where req and ack overlap
        stallReq = isMulDiv && !(mdReq && mdAck);
        accept = in.valid && !stallReq;

        nextPc = in.pc + (in.isCompressed ? ExecTypes::word_t'(ExecTypes::CompressedInsnBytes)
                                          : ExecTypes::word_t'(ExecTypes::InsnBytes));
        branchTaken = in.valid && op.unit == ExecTypes::ExecUnitBranch && condTaken;
        flushReq = accept && (branchTaken || trap.valid);
        flushTarget = branchTaken ? branchTarget : nextPc;

        if (op.writeSrc == ExecTypes::WriteSrcNextPc) begin
            dstValue = nextPc;
        end else if (op.unit == ExecTypes::ExecUnitMulDiv) begin
            dstValue = mdResult;
        end else begin
            dstValue = aluResult;
        end
    end

    // request drops right after the ack is seen
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mdReq <= 1'b0;
        end else if (mdReq && mdAck) begin
            mdReq <= 1'b0;
        end else if (isMulDiv && !mdAck) begin
            mdReq <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out <= '0;
        end else if (stallReq) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= accept;
            out.pc <= in.pc;
            out.rd <= op.rd;
            out.regWrite <= op.regWrite;
            out.dstValue <= dstValue;
            out.branchTaken <= branchTaken;
            out.branchTarget <= branchTarget;
            out.trap <= trap;
        end
    end

    bubbleOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stallReq |=> !out.valid);

endmodule

// ==== hdl/TrapDetect.sv ====
// ======================================
// Trap detection for ecall and ebreak
// ======================================
`timescale 1ns/1ps

module TrapDetect (
    input  logic                  valid,
    input  ExecTypes::execOp_t    op,
    input  ExecTypes::privilege_t privilege,
    output ExecTypes::trapInfo_t  trap
);

    always_comb begin
        trap = '0;
        if (valid && op.unit == ExecTypes::ExecUnitTrap) begin
            trap.valid = 1'b1;
            // both traps report a zero tval
            trap.value = '0;
            if (op.trapOp == ExecTypes::TrapOpEbreak) begin
                trap.cause = ExecTypes::CauseBreakpoint;
            end else begin
                case (privilege)
                    ExecTypes::PrivilegeUser:       trap.cause = ExecTypes::CauseEcallFromU;
                    ExecTypes::PrivilegeSupervisor: trap.cause = ExecTypes::CauseEcallFromS;
                    default:                        trap.cause = ExecTypes::CauseEcallFromM;
                endcase
            end
        end
    end

endmodule

// ==== hdl/MulDivUnit.sv ====
// ======================================
// Multi-cycle multiply/divide unit
// four-phase req/ack handshake
// multiply in 2 cycles, restoring divide
// ======================================
`timescale 1ns/1ps

module MulDivUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   mdReq,
    input  ExecTypes::mulDivReq_t  mdArgs,
    output logic                   mdAck,
    output ExecTypes::word_t       mdResult
);

    typedef enum logic [1:0] {Idle, Busy, Done, WaitLow} state_t;

    state_t state;
    ExecTypes::mulDivReq_t args;
    ExecTypes::word_t quotient;
    ExecTypes::word_t remainder;
    ExecTypes::word_t divisorMag;
    logic [ExecTypes::XlenLog2-1:0] count;

    logic isMul;
    logic isRem;
    logic signedDiv;
    logic divByZero;
    logic overflow;
    logic lastStep;
    logic finish;
    logic latchSigned;
    logic signed [ExecTypes::Xlen:0] mulOp1;
    logic signed [ExecTypes::Xlen:0] mulOp2;
    logic signed [2*ExecTypes::Xlen-1:0] product;
    ExecTypes::word_t mulResult;
    logic [ExecTypes::Xlen:0] remShifted;
    logic [ExecTypes::Xlen:0] diff;
    ExecTypes::word_t nextQuot;
    ExecTypes::word_t nextRem;
    ExecTypes::word_t fixedResult;

    always_comb begin
        isMul = args.cmd inside {ExecTypes::MulDivCmdMul, ExecTypes::MulDivCmdMulh,
                                 ExecTypes::MulDivCmdMulhsu, ExecTypes::MulDivCmdMulhu};
        isRem = args.cmd inside {ExecTypes::MulDivCmdRem, ExecTypes::MulDivCmdRemu};
        signedDiv = args.cmd inside {ExecTypes::MulDivCmdDiv, ExecTypes::MulDivCmdRem};
        divByZero = args.src2 == '0;
        overflow = signedDiv && args.src1 == {1'b1, {(ExecTypes::Xlen-1){1'b0}}} && &args.src2;
        lastStep = &count;
        finish = isMul || divByZero || overflow || lastStep;

        // sign extension picks mulh/mulhsu/mulhu
        mulOp1 = {(args.cmd inside {ExecTypes::MulDivCmdMulh, ExecTypes::MulDivCmdMulhsu})
                  && args.src1[ExecTypes::Xlen-1], args.src1};
        mulOp2 = {args.cmd == ExecTypes::MulDivCmdMulh && args.src2[ExecTypes::Xlen-1],
                  args.src2};
        product = mulOp1 * mulOp2;
        mulResult = (args.cmd == ExecTypes::MulDivCmdMul) ? product[ExecTypes::Xlen-1:0]
                                                         : product[2*ExecTypes::Xlen-1:ExecTypes::Xlen];

        // one restoring step
        remShifted = {remainder, quotient[ExecTypes::Xlen-1]};
        diff = remShifted - {1'b0, divisorMag};
        if (!diff[ExecTypes::Xlen]) begin
            nextRem = diff[ExecTypes::Xlen-1:0];
            nextQuot = {quotient[ExecTypes::Xlen-2:0], 1'b1};
        end else begin
            nextRem = remShifted[ExecTypes::Xlen-1:0];
            nextQuot = {quotient[ExecTypes::Xlen-2:0], 1'b0};
        end

        // remainder takes the dividend sign
        if (isRem) begin
            fixedResult = (signedDiv && args.src1[ExecTypes::Xlen-1]) ? -nextRem : nextRem;
        end else begin
            fixedResult = (signedDiv && (args.src1[ExecTypes::Xlen-1] ^ args.src2[ExecTypes::Xlen-1]))
                          ? -nextQuot : nextQuot;
        end

        latchSigned = mdArgs.cmd inside {ExecTypes::MulDivCmdDiv, ExecTypes::MulDivCmdRem};
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= Idle;
            mdAck <= 1'b0;
        end else begin
            case (state)
                Idle: if (mdReq) state <= Busy;
                Busy: begin
                    if (finish) begin
                        state <= Done;
                        mdAck <= 1'b1;
                    end
                end
                Done: begin
                    if (mdReq) begin
                        state <= WaitLow;
                    end else begin
                        state <= Idle;
                        mdAck <= 1'b0;
                    end
                end
                WaitLow: begin
                    if (!mdReq) begin
                        state <= Idle;
                        mdAck <= 1'b0;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == Idle && mdReq) begin
            args <= mdArgs;
            quotient <= (latchSigned && mdArgs.src1[ExecTypes::Xlen-1]) ? -mdArgs.src1
                                                                        : mdArgs.src1;
            divisorMag <= (latchSigned && mdArgs.src2[ExecTypes::Xlen-1]) ? -mdArgs.src2
                                                                          : mdArgs.src2;
            remainder <= '0;
            count <= '0;
        end else if (state == Busy) begin
            if (isMul) begin
                mdResult <= mulResult;
            end else if (divByZero) begin
                mdResult <= isRem ? args.src1 : '1;
            end else if (overflow) begin
                mdResult <= isRem ? '0 : args.src1;
            end else begin
                quotient <= nextQuot;
                remainder <= nextRem;
                count <= count + 1'b1;
                if (lastStep) mdResult <= fixedResult;
            end
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(mdAck) |-> mdReq);

    resultHeld: assert property (@(posedge clk) disable iff (!rstN)
        mdAck && $past(mdAck) |-> $stable(mdResult));

endmodule

// ==== hdl/BranchUnit.sv ====
// ======================================
// Branch condition and target
// ======================================
`timescale 1ns/1ps

module BranchUnit (
    input  ExecTypes::branchCond_t cond,
    input  logic                   indirect,
    input  ExecTypes::word_t       pc,
    input  ExecTypes::word_t       rs1Value,
    input  ExecTypes::word_t       rs2Value,
    input  ExecTypes::word_t       imm,
    output logic                   taken,
    output ExecTypes::word_t       target
);

    logic equal;
    logic lessSigned;
    logic lessUnsigned;
    ExecTypes::word_t base;
    ExecTypes::word_t sum;

    always_comb begin
        equal = rs1Value == rs2Value;
        lessSigned = $signed(rs1Value) < $signed(rs2Value);
        lessUnsigned = rs1Value < rs2Value;

        case (cond)
            ExecTypes::BranchCondEq:     taken = equal;
            ExecTypes::BranchCondNe:     taken = !equal;
            ExecTypes::BranchCondLt:     taken = lessSigned;
            ExecTypes::BranchCondGe:     taken = !lessSigned;
            ExecTypes::BranchCondLtu:    taken = lessUnsigned;
            ExecTypes::BranchCondGeu:    taken = !lessUnsigned;
            ExecTypes::BranchCondAlways: taken = 1'b1;
            default:                     taken = 1'b0;
        endcase

        // jalr computes from rs1 and drops bit 0
        base = indirect ? rs1Value : pc;
        sum = base + imm;
        target = indirect ? {sum[ExecTypes::Xlen-1:1], 1'b0} : sum;
    end

endmodule

// ==== hdl/IntAlu.sv ====
// ======================================
// Integer ALU
// combinational, twelve commands
// ======================================
`timescale 1ns/1ps

module IntAlu (
    input  ExecTypes::aluCmd_t cmd,
    input  ExecTypes::word_t   src1,
    input  ExecTypes::word_t   src2,
    output ExecTypes::word_t   result
);

    logic [ExecTypes::XlenLog2-1:0] shamt;
    logic lessSigned;
    logic lessUnsigned;

    always_comb begin
        shamt = src2[ExecTypes::XlenLog2-1:0];
        lessSigned = $signed(src1) < $signed(src2);
        lessUnsigned = src1 < src2;

        case (cmd)
            ExecTypes::AluCmdAdd:    result = src1 + src2;
            ExecTypes::AluCmdSub:    result = src1 - src2;
            ExecTypes::AluCmdSll:    result = src1 << shamt;
            ExecTypes::AluCmdSlt:    result = ExecTypes::word_t'(lessSigned);
            ExecTypes::AluCmdSltu:   result = ExecTypes::word_t'(lessUnsigned);
            ExecTypes::AluCmdXor:    result = src1 ^ src2;
            ExecTypes::AluCmdSrl:    result = src1 >> shamt;
            ExecTypes::AluCmdSra:    result = ExecTypes::word_t'($signed(src1) >>> shamt);
            ExecTypes::AluCmdOr:     result = src1 | src2;
            ExecTypes::AluCmdAnd:    result = src1 & src2;
            ExecTypes::AluCmdClear1: result = src1 & ~src2;
            ExecTypes::AluCmdClear2: result = ~src1 & src2;
            default:                 result = '0;
        endcase
    end

    // decoder must never hand over the four spare encodings
    always_comb begin
        if (!$isunknown(cmd)) begin
            aluCmdDefined: assert final (cmd <= ExecTypes::AluCmdClear2)
                else $error("IntAlu undefined command %0d", cmd);
        end
    end

endmodule

// ==== hdl/ExecTypes.sv ====
// ======================================
// Shared definitions of the execute stage
// widths, cause codes, operation encodings
// and the stage input/output structs
// ======================================
package ExecTypes;

    localparam int Xlen = 32;
    localparam int XlenLog2 = 5;
    localparam int RegAddrWidth = 5;
    localparam int CauseWidth = 5;
    localparam int InsnBytes = 4;
    localparam int CompressedInsnBytes = 2;

    // exception codes from the privileged spec
    localparam logic [CauseWidth-1:0] CauseBreakpoint = 5'd3;
    localparam logic [CauseWidth-1:0] CauseEcallFromU = 5'd8;
    localparam logic [CauseWidth-1:0] CauseEcallFromS = 5'd9;
    localparam logic [CauseWidth-1:0] CauseEcallFromM = 5'd11;

    typedef logic [Xlen-1:0] word_t;
    typedef logic [RegAddrWidth-1:0] regAddr_t;

    typedef enum logic [1:0] {
        ExecUnitAlu,
        ExecUnitBranch,
        ExecUnitMulDiv,
        ExecUnitTrap
    } execUnit_t;

    typedef enum logic [3:0] {
        AluCmdAdd,
        AluCmdSub,
        AluCmdSll,
        AluCmdSlt,
        AluCmdSltu,
        AluCmdXor,
        AluCmdSrl,
        AluCmdSra,
        AluCmdOr,
        AluCmdAnd,
        AluCmdClear1,
        AluCmdClear2
    } aluCmd_t;

    typedef enum logic [1:0] {AluSrc1Zero, AluSrc1Pc, AluSrc1Reg} aluSrc1_t;
    typedef enum logic [1:0] {AluSrc2Zero, AluSrc2Imm, AluSrc2Reg} aluSrc2_t;
    typedef enum logic {WriteSrcResult, WriteSrcNextPc} writeSrc_t;

    typedef enum logic [2:0] {
        BranchCondEq,
        BranchCondNe,
        BranchCondLt,
        BranchCondGe,
        BranchCondLtu,
        BranchCondGeu,
        BranchCondAlways
    } branchCond_t;

    typedef enum logic [2:0] {
        MulDivCmdMul,
        MulDivCmdMulh,
        MulDivCmdMulhsu,
        MulDivCmdMulhu,
        MulDivCmdDiv,
        MulDivCmdDivu,
        MulDivCmdRem,
        MulDivCmdRemu
    } mulDivCmd_t;

    typedef enum logic {TrapOpEcall, TrapOpEbreak} trapOp_t;

    typedef enum logic [1:0] {
        PrivilegeUser = 2'd0,
        PrivilegeSupervisor = 2'd1,
        PrivilegeMachine = 2'd3
    } privilege_t;

    typedef struct packed {
        execUnit_t unit;
        aluCmd_t aluCmd;
        aluSrc1_t aluSrc1;
        aluSrc2_t aluSrc2;
        writeSrc_t writeSrc;
        branchCond_t branchCond;
        logic indirect;
        mulDivCmd_t mulDivCmd;
        trapOp_t trapOp;
        word_t imm;
        regAddr_t rd;
        logic regWrite;
    } execOp_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        word_t insn;
        logic isCompressed;
        execOp_t op;
        word_t rs1Value;
        word_t rs2Value;
    } stageIn_t;

    typedef struct packed {
        logic valid;
        logic [CauseWidth-1:0] cause;
        word_t value;
    } trapInfo_t;

    typedef struct packed {
        logic valid;
        word_t pc;
        regAddr_t rd;
        logic regWrite;
        word_t dstValue;
        logic branchTaken;
        word_t branchTarget;
        trapInfo_t trap;
    } stageOut_t;

    typedef struct packed {
        mulDivCmd_t cmd;
        word_t src1;
        word_t src2;
    } mulDivReq_t;

endpackage
